/* hw/timer_pkg.sv */
// Timer shared definitions
package timer_pkg;

    // Bus widths
    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // TAC bit 2 is the enable, bits 1:0 pick the rate tap
    typedef logic [2:0]  tac_t;

    // Rate counter feeding the four taps
    typedef logic [10:0] rate_count_t;

    // Tap edge detector
    typedef enum logic [0:0] {
        TICK_IDLE = 1'b0,
        TICK_SEEN = 1'b1
    } tick_state_t;

    // Register offsets from the timer base
    localparam bus_addr_t ADDR_DIV_OFS  = 16'd0;
    localparam bus_addr_t ADDR_TIMA_OFS = 16'd1;
    localparam bus_addr_t ADDR_TMA_OFS  = 16'd2;
    localparam bus_addr_t ADDR_TAC_OFS  = 16'd3;

    // Default bus locations
    localparam bus_addr_t DEFAULT_TIMER_BASE = 16'hFF04;
    localparam bus_addr_t DEFAULT_IF_ADDR    = 16'hFF0F;

    // Timer flag position in IF
    localparam int IRQ_TIMER_BIT = 2;

    // Enable bit in TAC
    localparam int TAC_ENABLE_BIT = 2;

    // Rate counter taps per TAC rate select
    // 00 -> 4096 Hz, 01 -> 262144 Hz, 10 -> 65536 Hz, 11 -> 16384 Hz
    localparam int TAP_RATE_00 = 10;
    localparam int TAP_RATE_01 = 4;
    localparam int TAP_RATE_10 = 6;
    localparam int TAP_RATE_11 = 8;

endpackage

/* hw/timer_bus_decode.sv */
// Timer bus decoder
module timer_bus_decode
    import timer_pkg::*;
#(
    parameter bus_addr_t TIMER_BASE = DEFAULT_TIMER_BASE,
    parameter bus_addr_t IF_ADDR    = DEFAULT_IF_ADDR
) (
    input  bus_addr_t addr,
    input  logic      re_n,
    input  logic      we_n,
    output logic      div_we,
    output logic      tima_we,
    output logic      tma_we,
    output logic      tac_we,
    output logic      if_we,
    output logic      div_re,
    output logic      tima_re,
    output logic      tma_re,
    output logic      tac_re,
    output logic      if_re
);

    // Absolute register addresses
    localparam bus_addr_t DIV_ADDR  = TIMER_BASE + ADDR_DIV_OFS;
    localparam bus_addr_t TIMA_ADDR = TIMER_BASE + ADDR_TIMA_OFS;
    localparam bus_addr_t TMA_ADDR  = TIMER_BASE + ADDR_TMA_OFS;
    localparam bus_addr_t TAC_ADDR  = TIMER_BASE + ADDR_TAC_OFS;

    // One bit per register, ordered DIV, TIMA, TMA, TAC, IF from bit 0
    logic [4:0] match;
    logic [4:0] wr_sel;
    logic [4:0] rd_sel;

    always_comb begin
        match    = '0;
        match[0] = (addr == DIV_ADDR);
        match[1] = (addr == TIMA_ADDR);
        match[2] = (addr == TMA_ADDR);
        match[3] = (addr == TAC_ADDR);
        match[4] = (addr == IF_ADDR);

        // An IF address placed inside the timer block would select two registers
        assert ($onehot0(match))
            else $error("timer decode: address 0x%h selects more than one register", addr);
    end

    // Strobes are active low
    assign wr_sel = we_n ? 5'b0 : match;
    assign rd_sel = re_n ? 5'b0 : match;

    assign div_we  = wr_sel[0];
    assign tima_we = wr_sel[1];
    assign tma_we  = wr_sel[2];
    assign tac_we  = wr_sel[3];
    assign if_we   = wr_sel[4];

    assign div_re  = rd_sel[0];
    assign tima_re = rd_sel[1];
    assign tma_re  = rd_sel[2];
    assign tac_re  = rd_sel[3];
    assign if_re   = rd_sel[4];

endmodule

/* hw/timer_divider.sv */
// Timer prescaler and rate counter
module timer_divider
    import timer_pkg::*;
(
    input  logic        I_CLOCK,
    input  logic        I_RESET,
    input  logic        div_we,
    input  tac_t        tac,
    output bus_data_t   div_value,
    output rate_count_t rate_count
);

    bus_data_t prescaler;
    bus_data_t prescaler_next;
    logic      prescaler_carry;
    logic      rate_enable;

    // Carry out of the prescaler drives the DIV increment
    assign {prescaler_carry, prescaler_next} = {1'b0, prescaler} + 9'd1;

    assign rate_enable = tac[TAC_ENABLE_BIT];

    // Prescaler runs every cycle from reset, DIV writes leave it alone
    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            prescaler <= '0;
        end else begin
            prescaler <= prescaler_next;
        end
    end

    // DIV counts prescaler wraps
    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            div_value <= '0;
        end else if (div_we) begin
            // Any write clears, the written value is ignored
            div_value <= '0;
        end else if (prescaler_carry) begin
            div_value <= div_value + 8'd1;
        end
    end

    // Rate counter only moves while the timer is enabled
    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            rate_count <= '0;
        end else if (rate_enable) begin
            rate_count <= rate_count + 11'd1;
        end
    end

endmodule

/* hw/timer_tima_unit.sv */
// Timer counter unit
module timer_tima_unit
    import timer_pkg::*;
(
    input  logic        I_CLOCK,
    input  logic        I_RESET,
    input  rate_count_t rate_count,
    input  bus_data_t   wdata,
    input  logic        tima_we,
    input  logic        tma_we,
    input  logic        tac_we,
    output bus_data_t   tima_value,
    output bus_data_t   tma_value,
    output tac_t        tac,
    output logic        ovf_pulse
);

    tick_state_t state;
    tick_state_t next_state;
    logic        tap;
    logic        tick;
    logic        tima_full;

    // Rate tap select
    always_comb begin
        case (tac[1:0])
            2'b00:   tap = rate_count[TAP_RATE_00];
            2'b01:   tap = rate_count[TAP_RATE_01];
            2'b10:   tap = rate_count[TAP_RATE_10];
            default: tap = rate_count[TAP_RATE_11];
        endcase
    end

    // One tick per rising edge of the tap, only while enabled
    assign tick = tac[TAC_ENABLE_BIT] && tap && (state == TICK_IDLE);

    always_comb begin
        next_state = state;
        case (state)
            TICK_IDLE: begin
                if (tick) begin
                    next_state = TICK_SEEN;
                end
            end
            TICK_SEEN: begin
                // Wait for the tap to fall before arming again
                if (!tap) begin
                    next_state = TICK_IDLE;
                end
            end
            default: next_state = TICK_IDLE;
        endcase
    end

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            state <= TICK_IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign tima_full = (tima_value == 8'hFF);

    // Wrap only when the tick actually reaches TIMA
    assign ovf_pulse = tick && tima_full && !tima_we;

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            tima_value <= '0;
        end else if (tima_we) begin
            tima_value <= wdata;
        end else if (tick) begin
            if (tima_full) begin
                // A TMA write in the wrap cycle goes straight into TIMA
                tima_value <= tma_we ? wdata : tma_value;
            end else begin
                tima_value <= tima_value + 8'd1;
            end
        end
    end

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            tma_value <= '0;
            tac       <= '0;
        end else begin
            if (tma_we) begin
                tma_value <= wdata;
            end
            if (tac_we) begin
                tac <= wdata[2:0];
            end
        end
    end

    assert property (@(posedge I_CLOCK) disable iff (I_RESET) ovf_pulse |-> tac[TAC_ENABLE_BIT])
        else $error("timer: overflow while the timer is disabled");

    assert property (@(posedge I_CLOCK) disable iff (I_RESET) tick |=> !tick)
        else $error("timer: ticks in back-to-back cycles");

endmodule

/* hw/timer_irq_readback.sv */
// Timer interrupt flag and read mux
module timer_irq_readback
    import timer_pkg::*;
(
    input  logic      I_CLOCK,
    input  logic      I_RESET,
    input  logic      ovf_pulse,
    input  logic      if_we,
    input  bus_data_t wdata,
    input  logic      div_re,
    input  logic      tima_re,
    input  logic      tma_re,
    input  logic      tac_re,
    input  logic      if_re,
    input  bus_data_t div_value,
    input  bus_data_t tima_value,
    input  bus_data_t tma_value,
    input  tac_t      tac,
    output bus_data_t rdata,
    output logic      irq
);

    logic      timer_flag;
    bus_data_t if_value;
    bus_data_t tac_value;

    // Overflow beats a same-cycle IF write
    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            timer_flag <= 1'b0;
        end else if (ovf_pulse) begin
            timer_flag <= 1'b1;
        end else if (if_we) begin
            timer_flag <= wdata[IRQ_TIMER_BIT];
        end
    end

    assign irq = timer_flag;

    // Only the timer bit of IF lives here
    always_comb begin
        if_value                = '0;
        if_value[IRQ_TIMER_BIT] = timer_flag;
    end

    assign tac_value = {5'b0, tac};

    // Combinational read, zero when nothing is selected
    always_comb begin
        if (div_re) begin
            rdata = div_value;
        end else if (tima_re) begin
            rdata = tima_value;
        end else if (tma_re) begin
            rdata = tma_value;
        end else if (tac_re) begin
            rdata = tac_value;
        end else if (if_re) begin
            rdata = if_value;
        end else begin
            rdata = '0;
        end
    end

endmodule

/* hw/timer_top.sv */
// Timer subsystem top
module timer_top
    import timer_pkg::*;
#(
    parameter bus_addr_t TIMER_BASE = DEFAULT_TIMER_BASE,
    parameter bus_addr_t IF_ADDR    = DEFAULT_IF_ADDR
) (
    input  logic      I_CLOCK,
    input  logic      I_RESET,
    input  bus_addr_t addr,
    input  bus_data_t wdata,
    input  logic      re_n,
    input  logic      we_n,
    output bus_data_t rdata,
    output logic      irq
);

    // Register selects
    logic div_we;
    logic tima_we;
    logic tma_we;
    logic tac_we;
    logic if_we;
    logic div_re;
    logic tima_re;
    logic tma_re;
    logic tac_re;
    logic if_re;

    // Register values
    bus_data_t   div_value;
    bus_data_t   tima_value;
    bus_data_t   tma_value;
    tac_t        tac;
    rate_count_t rate_count;
    logic        ovf_pulse;

    timer_bus_decode #(
        .TIMER_BASE (TIMER_BASE),
        .IF_ADDR    (IF_ADDR)
    ) u_decode (
        .addr    (addr),
        .re_n    (re_n),
        .we_n    (we_n),
        .div_we  (div_we),
        .tima_we (tima_we),
        .tma_we  (tma_we),
        .tac_we  (tac_we),
        .if_we   (if_we),
        .div_re  (div_re),
        .tima_re (tima_re),
        .tma_re  (tma_re),
        .tac_re  (tac_re),
        .if_re   (if_re)
    );

    timer_divider u_divider (
        .I_CLOCK    (I_CLOCK),
        .I_RESET    (I_RESET),
        .div_we     (div_we),
        .tac        (tac),
        .div_value  (div_value),
        .rate_count (rate_count)
    );

    timer_tima_unit u_tima (
        .I_CLOCK    (I_CLOCK),
        .I_RESET    (I_RESET),
        .rate_count (rate_count),
        .wdata      (wdata),
        .tima_we    (tima_we),
        .tma_we     (tma_we),
        .tac_we     (tac_we),
        .tima_value (tima_value),
        .tma_value  (tma_value),
        .tac        (tac),
        .ovf_pulse  (ovf_pulse)
    );

    timer_irq_readback u_readback (
        .I_CLOCK    (I_CLOCK),
        .I_RESET    (I_RESET),
        .ovf_pulse  (ovf_pulse),
        .if_we      (if_we),
        .wdata      (wdata),
        .div_re     (div_re),
        .tima_re    (tima_re),
        .tma_re     (tma_re),
        .tac_re     (tac_re),
        .if_re      (if_re),
        .div_value  (div_value),
        .tima_value (tima_value),
        .tma_value  (tma_value),
        .tac        (tac),
        .rdata      (rdata),
        .irq        (irq)
    );

endmodule

/* sim/timer_tb.sv */
// Timer testbench
module timer_tb
    import timer_pkg::*;
;

    localparam string     STIM_FILE    = "sim/timer_stimulus.txt";
    localparam int        IRQ_TIMEOUT  = 5000;
    localparam int        TICK_TIMEOUT = 5000;
    localparam bus_addr_t DIV_ADDR     = DEFAULT_TIMER_BASE + ADDR_DIV_OFS;
    localparam bus_addr_t TIMA_ADDR    = DEFAULT_TIMER_BASE + ADDR_TIMA_OFS;
    localparam bus_addr_t TMA_ADDR     = DEFAULT_TIMER_BASE + ADDR_TMA_OFS;
    localparam bus_addr_t TAC_ADDR     = DEFAULT_TIMER_BASE + ADDR_TAC_OFS;

    logic      I_CLOCK;
    logic      I_RESET;
    bus_addr_t addr;
    bus_data_t wdata;
    logic      re_n;
    logic      we_n;
    bus_data_t rdata;
    logic      irq;

    reg [8*32-1:0] test_name;

    // Reference model state
    bus_data_t   m_presc;
    bus_data_t   m_div;
    rate_count_t m_rate;
    tick_state_t m_state;
    bus_data_t   m_tima;
    bus_data_t   m_tma;
    tac_t        m_tac;
    logic        m_flag;

    timer_top dut (
        .I_CLOCK (I_CLOCK),
        .I_RESET (I_RESET),
        .addr    (addr),
        .wdata   (wdata),
        .re_n    (re_n),
        .we_n    (we_n),
        .rdata   (rdata),
        .irq     (irq)
    );

    always #2 I_CLOCK = ~I_CLOCK;

    // Tap bit of the rate counter for each TAC rate select
    function automatic logic rate_tap(input tac_t t, input rate_count_t r);
        case (t[1:0])
            2'b00:   rate_tap = r[10];
            2'b01:   rate_tap = r[4];
            2'b10:   rate_tap = r[6];
            default: rate_tap = r[8];
        endcase
    endfunction

    // True when the current cycle of the model is a tick cycle
    function automatic logic model_tick_now();
        return m_tac[2] && rate_tap(m_tac, m_rate) && (m_state == TICK_IDLE);
    endfunction

    function automatic bus_data_t model_read(input bus_addr_t a);
        bus_data_t v;
        v = '0;
        if (a == DIV_ADDR) begin
            v = m_div;
        end else if (a == TIMA_ADDR) begin
            v = m_tima;
        end else if (a == TMA_ADDR) begin
            v = m_tma;
        end else if (a == TAC_ADDR) begin
            v = {5'b0, m_tac};
        end else if (a == DEFAULT_IF_ADDR) begin
            v[IRQ_TIMER_BIT] = m_flag;
        end
        return v;
    endfunction

    // Cycle model, stepped with the same bus inputs as the DUT
    always @(posedge I_CLOCK or posedge I_RESET) begin : model_step
        logic w_div;
        logic w_tima;
        logic w_tma;
        logic w_tac;
        logic w_if;
        logic tap;
        logic tick;
        logic ovf;
        if (I_RESET) begin
            m_presc <= '0;
            m_div   <= '0;
            m_rate  <= '0;
            m_state <= TICK_IDLE;
            m_tima  <= '0;
            m_tma   <= '0;
            m_tac   <= '0;
            m_flag  <= 1'b0;
        end else begin
            w_div  = !we_n && (addr == DIV_ADDR);
            w_tima = !we_n && (addr == TIMA_ADDR);
            w_tma  = !we_n && (addr == TMA_ADDR);
            w_tac  = !we_n && (addr == TAC_ADDR);
            w_if   = !we_n && (addr == DEFAULT_IF_ADDR);
            tap    = rate_tap(m_tac, m_rate);
            tick   = m_tac[2] && tap && (m_state == TICK_IDLE);
            ovf    = tick && (m_tima == 8'hFF) && !w_tima;

            m_presc <= m_presc + 8'd1;
            if (w_div) begin
                m_div <= '0;
            end else if (m_presc == 8'hFF) begin
                m_div <= m_div + 8'd1;
            end
            if (m_tac[2]) begin
                m_rate <= m_rate + 11'd1;
            end

            if (tick) begin
                m_state <= TICK_SEEN;
            end else if ((m_state == TICK_SEEN) && !tap) begin
                m_state <= TICK_IDLE;
            end

            // TIMA write wins, a TMA write in the wrap cycle is loaded directly
            if (w_tima) begin
                m_tima <= wdata;
            end else if (tick) begin
                if (m_tima == 8'hFF) begin
                    m_tima <= w_tma ? wdata : m_tma;
                end else begin
                    m_tima <= m_tima + 8'd1;
                end
            end
            if (w_tma) begin
                m_tma <= wdata;
            end
            if (w_tac) begin
                m_tac <= wdata[2:0];
            end

            if (ovf) begin
                m_flag <= 1'b1;
            end else if (w_if) begin
                m_flag <= wdata[IRQ_TIMER_BIT];
            end
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("Test %0s: %0s", test_name, reason);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    task automatic check_data(input string what, input bus_data_t expected,
                              input bus_data_t actual);
        if (actual !== expected) begin
            $display("Error: test %0s (%0s) expected 0x%h actual 0x%h",
                     test_name, what, expected, actual);
            $display("** FAIL **");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_irq(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: test %0s (%0s) expected %b actual %b",
                     test_name, what, expected, actual);
            $display("** FAIL **");
            $fatal(1, "irq mismatch");
        end
    endtask

    task automatic drive_idle_cycle();
        @(negedge I_CLOCK);
        addr  = '0;
        wdata = '0;
        re_n  = 1'b1;
        we_n  = 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            drive_idle_cycle();
        end
    endtask

    task automatic bus_write(input bus_addr_t a, input bus_data_t d);
        @(negedge I_CLOCK);
        addr  = a;
        wdata = d;
        re_n  = 1'b1;
        we_n  = 1'b0;
    endtask

    // Reads are combinational, so sample a unit after the falling edge
    task automatic read_check(input bus_addr_t a, input logic use_file, input bus_data_t exp);
        @(negedge I_CLOCK);
        addr  = a;
        wdata = '0;
        re_n  = 1'b0;
        we_n  = 1'b1;
        #1;
        if (use_file) begin
            check_data("file", exp, rdata);
        end
        check_data("model", model_read(a), rdata);
    endtask

    // Place a write in the next cycle that the model marks as a tick
    task automatic write_on_tick(input bus_addr_t a, input bus_data_t d);
        int waited;
        waited = 0;
        drive_idle_cycle();
        while (!model_tick_now()) begin
            waited++;
            if (waited > TICK_TIMEOUT) begin
                stop_with_failure("no timer tick came within the tick timeout");
            end
            drive_idle_cycle();
        end
        addr  = a;
        wdata = d;
        we_n  = 1'b0;
    endtask

    // The model flag is compared in every cycle of the wait
    task automatic wait_irq(input logic level);
        int waited;
        waited = 0;
        drive_idle_cycle();
        check_irq("model", m_flag, irq);
        while (irq !== level) begin
            waited++;
            if (waited > IRQ_TIMEOUT) begin
                stop_with_failure($sformatf("irq did not reach %b within %0d cycles",
                                            level, IRQ_TIMEOUT));
            end
            drive_idle_cycle();
            check_irq("model", m_flag, irq);
        end
    endtask

    initial begin : run
        int             fd;
        int             code;
        int             seed;
        int             n;
        logic           done;
        logic           level;
        logic [7:0]     cmd;
        bus_addr_t      a;
        bus_data_t      d;
        reg [8*160-1:0] line_buf;
        I_CLOCK   = 1'b0;
        I_RESET   = 1'b1;
        addr      = '0;
        wdata     = '0;
        re_n      = 1'b1;
        we_n      = 1'b1;
        test_name = "startup";
        seed      = $urandom(74414);

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            stop_with_failure("cannot open the stimulus file");
        end

        repeat (10) @(posedge I_CLOCK);
        @(negedge I_CLOCK);
        I_RESET = 1'b0;

        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": code = $fgets(line_buf, fd);
                    "T": code = $fscanf(fd, "%s", test_name);
                    "W", "R", "S": begin
                        code = $fscanf(fd, "%h %h", a, d);
                        if (code != 2) begin
                            stop_with_failure("stimulus line lacks an address and a value");
                        end
                        if (cmd == "W") begin
                            bus_write(a, d);
                        end else if (cmd == "R") begin
                            read_check(a, 1'b1, d);
                        end else begin
                            write_on_tick(a, d);
                        end
                    end
                    "M": begin
                        code = $fscanf(fd, "%h", a);
                        if (code != 1) begin
                            stop_with_failure("stimulus read line lacks an address");
                        end
                        read_check(a, 1'b0, '0);
                    end
                    "I", "G": begin
                        code = $fscanf(fd, "%d", n);
                        if (code != 1) begin
                            stop_with_failure("stimulus idle line lacks a count");
                        end
                        // Random gap of 0 up to n cycles
                        if (cmd == "G") begin
                            n = $urandom % (n + 1);
                        end
                        idle_cycles(n);
                    end
                    "Q": begin
                        code = $fscanf(fd, "%h", level);
                        if (code != 1) begin
                            stop_with_failure("stimulus irq line lacks a level");
                        end
                        wait_irq(level);
                    end
                    default: stop_with_failure("unknown command in the stimulus file");
                endcase
            end
        end
        $fclose(fd);

        drive_idle_cycle();
        $display("** PASS **");
        $finish;
    end

endmodule

/* build.f */
hw/timer_pkg.sv
hw/timer_bus_decode.sv
hw/timer_divider.sv
hw/timer_tima_unit.sv
hw/timer_irq_readback.sv
hw/timer_top.sv
sim/timer_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the timer testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        -f build.f \
        --top-module timer_tb \
        --Mdir obj_dir \
        -o timer_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/timer_sim; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished"
exit 0

/* sim/timer_stimulus.txt */
# Columns: command then arguments, addresses and data in hex, counts in decimal
# W addr data | R addr expect | M addr (model only) | I n | G max | S addr data | Q irq | T name
T registers
W FF06 5A
R FF06 5A
W FF07 FC
R FF07 04
R FF00 00
R FF10 00
W FF07 00
R FF07 00
T divider
I 600
M FF04
G 200
M FF04
W FF04 33
M FF04
G 40
I 300
M FF04
T rates
W FF05 00
W FF07 04
I 2100
M FF05
W FF07 05
G 30
I 200
M FF05
W FF07 06
I 500
M FF05
W FF07 07
G 60
I 1000
M FF05
W FF07 03
W FF05 42
I 300
R FF05 42
T wrap
W FF06 A0
W FF05 FF
W FF07 05
Q 1
R FF05 A0
R FF0F 04
T wrap_tma_write
W FF05 FF
S FF06 C3
R FF05 C3
R FF06 C3
T if_clear
W FF0F 00
Q 0
R FF0F 00
W FF05 FE
Q 1
R FF0F 04
T tima_write_on_tick
G 20
S FF05 80
R FF05 80
M FF05
I 100
M FF05
